//--- Makefile
TOP := htable_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Result: FAILED" sim.log; then \
		echo "Simulation reported a failure"; \
		exit 1; \
	fi
	@if ! grep -q "Result: PASSED" sim.log; then \
		echo "Simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- hw/htable_bank.sv
`default_nettype none

module htable_bank #(
    parameter int HASH_SEL = 0
) (
    input  logic               clk,
    input  logic               rst,
    output logic               init_done,
    // Lookup read port
    input  logic               lookup_valid,
    input  htable_pkg::key_t   lookup_key,
    output htable_pkg::entry_t rd_entry,
    // Probe port for the update controller
    input  htable_pkg::key_t   probe_key,
    output htable_pkg::entry_t probe_entry,
    // Write port
    input  logic               wr_en,
    input  htable_pkg::entry_t wr_entry
);

    // ==========================================================
    // Index selection
    // ==========================================================
    function automatic htable_pkg::hash_t bank_hash(input htable_pkg::key_t key);
        htable_pkg::hash_t idx;
        if (HASH_SEL == 0) begin
            idx = htable_pkg::hash0(key);
        end else begin
            idx = htable_pkg::hash1(key);
        end
        return idx;
    endfunction

    htable_pkg::entry_t mem [htable_pkg::TABLE_SIZE];

    htable_pkg::hash_t lookup_idx;
    htable_pkg::hash_t probe_idx;
    htable_pkg::hash_t wr_idx;
    htable_pkg::hash_t init_cnt;

    assign lookup_idx = bank_hash(lookup_key);
    assign probe_idx  = bank_hash(probe_key);
    assign wr_idx     = bank_hash(wr_entry.key);

    // ==========================================================
    // Clearing sequence
    // ==========================================================
    // One slot per cycle, done flag set together with the last slot
    always_ff @(posedge clk) begin
        if (rst) begin
            init_cnt  <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            init_cnt <= init_cnt + 1'b1;
            if (init_cnt == htable_pkg::hash_t'(htable_pkg::TABLE_SIZE - 1)) begin
                init_done <= 1'b1;
            end
        end
    end

    // ==========================================================
    // Storage
    // ==========================================================
    // Clear writes own the array until init_done
    always_ff @(posedge clk) begin
        if (!init_done) begin
            mem[init_cnt] <= '0;
        end else if (wr_en) begin
            mem[wr_idx] <= wr_entry;
        end
    end

    // Registered lookup read, a same-cycle write is not seen
    always_ff @(posedge clk) begin
        if (lookup_valid) begin
            rd_entry <= mem[lookup_idx];
        end
    end

    // Combinational probe for the update decision
    assign probe_entry = mem[probe_idx];

endmodule

`default_nettype wire

//--- hw/htable_insert_ctrl.sv
`default_nettype none

module htable_insert_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       init_done,
    // Update handshake
    input  logic                       update_req,
    input  htable_pkg::update_t        update,
    output logic                       update_ack,
    output htable_pkg::update_status_t update_status,
    // Bank probe
    output htable_pkg::key_t           probe_key,
    input  htable_pkg::entry_t         probe_entry0,
    input  htable_pkg::entry_t         probe_entry1,
    // Bank writes
    output logic                       wr_en0,
    output logic                       wr_en1,
    output htable_pkg::entry_t         wr_entry
);

    typedef enum logic [1:0] {
        IDLE,
        CAPTURE,
        ACK
    } state_t;

    state_t state;

    htable_pkg::update_t upd_q;
    logic                rr_ptr;

    logic                       hit0;
    logic                       hit1;
    logic                       empty0;
    logic                       empty1;
    logic                       nxt_wr0;
    logic                       nxt_wr1;
    logic                       nxt_insert;
    htable_pkg::update_status_t nxt_status;
    htable_pkg::entry_t         nxt_entry;

    assign probe_key = upd_q.key;

    assign hit0   = probe_entry0.valid && (probe_entry0.key == upd_q.key);
    assign hit1   = probe_entry1.valid && (probe_entry1.key == upd_q.key);
    assign empty0 = !probe_entry0.valid;
    assign empty1 = !probe_entry1.valid;

    // ==========================================================
    // Bank choice
    // ==========================================================
    always_comb begin
        nxt_wr0         = 1'b0;
        nxt_wr1         = 1'b0;
        nxt_insert      = 1'b0;
        nxt_status      = '0;
        nxt_entry.valid = upd_q.set;
        nxt_entry.key   = upd_q.key;
        nxt_entry.value = upd_q.set ? upd_q.value : '0;
        if (upd_q.set) begin
            // Existing key first, then a free slot
            if (hit0) begin
                nxt_wr0 = 1'b1;
            end else if (hit1) begin
                nxt_wr1 = 1'b1;
            end else if (empty0 && empty1) begin
                nxt_wr0    = !rr_ptr;
                nxt_wr1    = rr_ptr;
                nxt_insert = 1'b1;
            end else if (empty0) begin
                nxt_wr0    = 1'b1;
                nxt_insert = 1'b1;
            end else if (empty1) begin
                nxt_wr1    = 1'b1;
                nxt_insert = 1'b1;
            end
            nxt_status.full = !(nxt_wr0 || nxt_wr1);
        end else begin
            if (hit0) begin
                nxt_wr0 = 1'b1;
            end else if (hit1) begin
                nxt_wr1 = 1'b1;
            end
        end
        nxt_status.done = nxt_wr0 || nxt_wr1;
    end

    // ==========================================================
    // Handshake FSM
    // ==========================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= IDLE;
            update_ack    <= 1'b0;
            update_status <= '0;
            wr_en0        <= 1'b0;
            wr_en1        <= 1'b0;
            rr_ptr        <= 1'b0;
        end else begin
            // Write enables are single-cycle pulses
            wr_en0 <= 1'b0;
            wr_en1 <= 1'b0;
            case (state)
                IDLE: begin
                    if (update_req && init_done) begin
                        state <= CAPTURE;
                    end
                end
                CAPTURE: begin
                    wr_en0        <= nxt_wr0;
                    wr_en1        <= nxt_wr1;
                    update_status <= nxt_status;
                    // Pointer moves on every new key, not on replace
                    if (nxt_insert) begin
                        rr_ptr <= !rr_ptr;
                    end
                    state <= ACK;
                end
                ACK: begin
                    // Ack rises with the write landing in the bank
                    if (!update_ack) begin
                        update_ack <= 1'b1;
                    end else if (!update_req) begin
                        update_ack <= 1'b0;
                        state      <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            upd_q <= update;
        end
        if (state == CAPTURE) begin
            wr_entry <= nxt_entry;
        end
    end

endmodule

`default_nettype wire

//--- hw/htable_lookup_merge.sv
`default_nettype none

module htable_lookup_merge (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       lookup_valid,
    input  htable_pkg::key_t           lookup_key,
    input  htable_pkg::entry_t         rd_entry0,
    input  htable_pkg::entry_t         rd_entry1,
    output logic                       result_valid,
    output htable_pkg::lookup_result_t result
);

    logic                       lookup_valid_q;
    htable_pkg::key_t           lookup_key_q;
    logic                       match0;
    logic                       match1;
    htable_pkg::lookup_result_t nxt_result;

    // ==========================================================
    // Align key with the bank read
    // ==========================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            lookup_valid_q <= 1'b0;
        end else begin
            lookup_valid_q <= lookup_valid;
        end
    end

    always_ff @(posedge clk) begin
        lookup_key_q <= lookup_key;
    end

    // ==========================================================
    // Compare and select
    // ==========================================================
    assign match0 = rd_entry0.valid && (rd_entry0.key == lookup_key_q);
    assign match1 = rd_entry1.valid && (rd_entry1.key == lookup_key_q);

    // Bank 0 wins if both match
    always_comb begin
        nxt_result = '0;
        if (match0) begin
            nxt_result.hit   = 1'b1;
            nxt_result.value = rd_entry0.value;
        end else if (match1) begin
            nxt_result.hit   = 1'b1;
            nxt_result.value = rd_entry1.value;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= lookup_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_valid_q) begin
            result <= nxt_result;
        end
    end

endmodule

`default_nettype wire

//--- hw/htable_multi_core.sv
`default_nettype none

module htable_multi_core (
    input  logic                       clk,
    input  logic                       rst,
    // Lookup
    input  logic                       lookup_valid,
    input  htable_pkg::key_t           lookup_key,
    output logic                       result_valid,
    output htable_pkg::lookup_result_t result,
    // Update
    input  logic                       update_req,
    input  htable_pkg::update_t        update,
    output logic                       update_ack,
    output htable_pkg::update_status_t update_status,
    // Status
    output logic                       init_done
);

    logic               bank_init_done0;
    logic               bank_init_done1;
    htable_pkg::entry_t rd_entry0;
    htable_pkg::entry_t rd_entry1;
    htable_pkg::key_t   probe_key;
    htable_pkg::entry_t probe_entry0;
    htable_pkg::entry_t probe_entry1;
    logic               wr_en0;
    logic               wr_en1;
    htable_pkg::entry_t wr_entry;

    assign init_done = bank_init_done0 && bank_init_done1;

    // ==========================================================
    // Banks
    // ==========================================================
    htable_bank #(
        .HASH_SEL (0)
    ) u_bank0 (
        .clk          (clk),
        .rst          (rst),
        .init_done    (bank_init_done0),
        .lookup_valid (lookup_valid),
        .lookup_key   (lookup_key),
        .rd_entry     (rd_entry0),
        .probe_key    (probe_key),
        .probe_entry  (probe_entry0),
        .wr_en        (wr_en0),
        .wr_entry     (wr_entry)
    );

    htable_bank #(
        .HASH_SEL (1)
    ) u_bank1 (
        .clk          (clk),
        .rst          (rst),
        .init_done    (bank_init_done1),
        .lookup_valid (lookup_valid),
        .lookup_key   (lookup_key),
        .rd_entry     (rd_entry1),
        .probe_key    (probe_key),
        .probe_entry  (probe_entry1),
        .wr_en        (wr_en1),
        .wr_entry     (wr_entry)
    );

    // ==========================================================
    // Update and lookup paths
    // ==========================================================
    htable_insert_ctrl u_insert (
        .clk           (clk),
        .rst           (rst),
        .init_done     (init_done),
        .update_req    (update_req),
        .update        (update),
        .update_ack    (update_ack),
        .update_status (update_status),
        .probe_key     (probe_key),
        .probe_entry0  (probe_entry0),
        .probe_entry1  (probe_entry1),
        .wr_en0        (wr_en0),
        .wr_en1        (wr_en1),
        .wr_entry      (wr_entry)
    );

    htable_lookup_merge u_merge (
        .clk          (clk),
        .rst          (rst),
        .lookup_valid (lookup_valid),
        .lookup_key   (lookup_key),
        .rd_entry0    (rd_entry0),
        .rd_entry1    (rd_entry1),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

`default_nettype wire

//--- hw/htable_pkg.sv
`default_nettype none

package htable_pkg;

    // ==========================================================
    // Sizes
    // ==========================================================
    localparam int KEY_WID    = 32;
    localparam int VALUE_WID  = 16;
    localparam int HASH_WID   = 6;
    localparam int TABLE_SIZE = 2**HASH_WID;
    localparam int NUM_BANKS  = 2;

    typedef logic [KEY_WID-1:0]   key_t;
    typedef logic [VALUE_WID-1:0] value_t;
    typedef logic [HASH_WID-1:0]  hash_t;

    // ==========================================================
    // Structs
    // ==========================================================
    // One stored slot
    typedef struct packed {
        logic   valid;
        key_t   key;
        value_t value;
    } entry_t;

    // Update request, set=0 means delete
    typedef struct packed {
        logic   set;
        key_t   key;
        value_t value;
    } update_t;

    typedef struct packed {
        logic done;
        logic full;
    } update_status_t;

    // Value reads as zero on a miss
    typedef struct packed {
        logic   hit;
        value_t value;
    } lookup_result_t;

    // ==========================================================
    // Hash functions
    // ==========================================================
    // Bank 0 index from the top of the key
    function automatic hash_t hash0(input key_t key);
        return key[KEY_WID-1 -: HASH_WID];
    endfunction

    // Bank 1 index from the bottom of the key
    function automatic hash_t hash1(input key_t key);
        return key[HASH_WID-1:0];
    endfunction

endpackage

`default_nettype wire

//--- tests/htable_properties.sv
`default_nettype none

module htable_properties (
    input logic clk,
    input logic rst,
    input logic init_done,
    input logic update_req,
    input logic update_ack,
    input logic wr_en0,
    input logic wr_en1
);

    // ==========================================================
    // Update handshake
    // ==========================================================
    ack_rise_with_req: assert property (
        @(posedge clk) disable iff (rst)
        $rose(update_ack) |-> $past(update_req)
    ) else $error("update_ack rose without update_req");

    // Ack may only fall once the request is gone
    ack_held_until_release: assert property (
        @(posedge clk) disable iff (rst)
        (update_ack && update_req) |=> update_ack
    ) else $error("update_ack fell while update_req was high");

    // ==========================================================
    // Bank writes
    // ==========================================================
    single_bank_write: assert property (
        @(posedge clk) disable iff (rst)
        !(wr_en0 && wr_en1)
    ) else $error("both banks written in one cycle");

    write_after_init: assert property (
        @(posedge clk) disable iff (rst)
        (wr_en0 || wr_en1) |-> init_done
    ) else $error("bank write before clearing finished");

endmodule

bind htable_insert_ctrl htable_properties u_properties (
    .clk        (clk),
    .rst        (rst),
    .init_done  (init_done),
    .update_req (update_req),
    .update_ack (update_ack),
    .wr_en0     (wr_en0),
    .wr_en1     (wr_en1)
);

`default_nettype wire

//--- tests/htable_tb.sv
`default_nettype none

module htable_tb;

    logic                       clk;
    logic                       rst;
    logic                       lookup_valid;
    htable_pkg::key_t           lookup_key;
    logic                       result_valid;
    htable_pkg::lookup_result_t result;
    logic                       update_req;
    htable_pkg::update_t        update;
    logic                       update_ack;
    htable_pkg::update_status_t update_status;
    logic                       init_done;

    // Reference copy of both banks
    htable_pkg::entry_t model0 [htable_pkg::TABLE_SIZE];
    htable_pkg::entry_t model1 [htable_pkg::TABLE_SIZE];
    logic               model_rr;

    htable_pkg::lookup_result_t exp_q [$];
    htable_pkg::key_t           known_keys [$];
    htable_pkg::key_t           coll_keys [3];
    htable_pkg::key_t           pool [8];
    string                      test_name;
    int                         seed;

    htable_multi_core DUT (
        .clk           (clk),
        .rst           (rst),
        .lookup_valid  (lookup_valid),
        .lookup_key    (lookup_key),
        .result_valid  (result_valid),
        .result        (result),
        .update_req    (update_req),
        .update        (update),
        .update_ack    (update_ack),
        .update_status (update_status),
        .init_done     (init_done)
    );

    always #2 clk = ~clk;

    // ==========================================================
    // Reporting
    // ==========================================================
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("ERROR: %s %s expected %h actual %h",
                                test_name, what, expected, actual));
        end
    endtask

    // ==========================================================
    // Reference model
    // ==========================================================
    // Bank 0 wins when both hold the key
    function automatic htable_pkg::lookup_result_t expected_lookup(
        input htable_pkg::key_t key);
        htable_pkg::lookup_result_t r;
        htable_pkg::entry_t         e0;
        htable_pkg::entry_t         e1;
        e0 = model0[htable_pkg::hash0(key)];
        e1 = model1[htable_pkg::hash1(key)];
        r  = '0;
        if (e0.valid && e0.key == key) begin
            r.hit   = 1'b1;
            r.value = e0.value;
        end else if (e1.valid && e1.key == key) begin
            r.hit   = 1'b1;
            r.value = e1.value;
        end
        return r;
    endfunction

    task automatic apply_model_update(input htable_pkg::update_t u,
                                      output htable_pkg::update_status_t st);
        htable_pkg::hash_t i0;
        htable_pkg::hash_t i1;
        logic              h0;
        logic              h1;
        int                bank;
        i0   = htable_pkg::hash0(u.key);
        i1   = htable_pkg::hash1(u.key);
        h0   = model0[i0].valid && model0[i0].key == u.key;
        h1   = model1[i1].valid && model1[i1].key == u.key;
        bank = -1;
        st   = '0;
        if (u.set) begin
            if (h0) begin
                bank = 0;
            end else if (h1) begin
                bank = 1;
            end else begin
                // New key goes to the round-robin bank when both slots are free
                if (!model0[i0].valid && !model1[i1].valid) begin
                    bank = model_rr ? 1 : 0;
                end else if (!model0[i0].valid) begin
                    bank = 0;
                end else if (!model1[i1].valid) begin
                    bank = 1;
                end
                if (bank >= 0) begin
                    model_rr = !model_rr;
                end
            end
            st.full = (bank < 0);
            if (bank == 0) begin
                model0[i0].valid = 1'b1;
                model0[i0].key   = u.key;
                model0[i0].value = u.value;
            end else if (bank == 1) begin
                model1[i1].valid = 1'b1;
                model1[i1].key   = u.key;
                model1[i1].value = u.value;
            end
        end else begin
            if (h0) begin
                model0[i0].valid = 1'b0;
                bank = 0;
            end else if (h1) begin
                model1[i1].valid = 1'b0;
                bank = 1;
            end
        end
        st.done = (bank >= 0);
    endtask

    // ==========================================================
    // Waits and drivers
    // ==========================================================
    task automatic wait_for_init();
        int cycles;
        for (cycles = 0; cycles < 100; cycles++) begin
            @(negedge clk);
            if (init_done === 1'b1) break;
        end
        if (cycles == 100) begin
            abort_run("init_done did not rise after reset");
        end
    endtask

    task automatic await_ack(input logic level);
        int cycles;
        for (cycles = 0; cycles < 20; cycles++) begin
            @(negedge clk);
            if (update_ack === level) break;
        end
        if (cycles == 20) begin
            abort_run($sformatf("update_ack did not reach %0d in time", level));
        end
    endtask

    task automatic drain_results();
        int cycles;
        for (cycles = 0; cycles < 20; cycles++) begin
            @(negedge clk);
            if (exp_q.size() == 0) break;
        end
        if (cycles == 20) begin
            abort_run("Lookup results did not arrive in time");
        end
    endtask

    task automatic issue_lookup(input htable_pkg::key_t key);
        @(posedge clk);
        lookup_valid <= 1'b1;
        lookup_key   <= key;
        exp_q.push_back(expected_lookup(key));
    endtask

    task automatic stop_lookups();
        @(posedge clk);
        lookup_valid <= 1'b0;
    endtask

    // Full four-phase handshake with the status checked while ack is high
    task automatic run_update(input logic set, input htable_pkg::key_t key,
                              input htable_pkg::value_t value);
        htable_pkg::update_t        u;
        htable_pkg::update_status_t exp_status;
        u.set   = set;
        u.key   = key;
        u.value = value;
        apply_model_update(u, exp_status);
        @(posedge clk);
        update_req <= 1'b1;
        update     <= u;
        await_ack(1'b1);
        check_value("update status", 32'(exp_status), 32'(update_status));
        @(posedge clk);
        update_req <= 1'b0;
        await_ack(1'b0);
    endtask

    // Lookup results are compared in issue order
    always @(negedge clk) begin
        htable_pkg::lookup_result_t expected;
        if (result_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                abort_run("Lookup result arrived with no lookup pending");
            end else begin
                expected = exp_q.pop_front();
                check_value("lookup", 32'(expected), 32'(result));
            end
        end
    end

    // ==========================================================
    // Test sequence
    // ==========================================================
    initial begin
        htable_pkg::key_t k;
        logic [31:0]      rnd;
        seed         = 32'he18f;
        clk          = 1'b0;
        rst          = 1'b1;
        lookup_valid = 1'b0;
        lookup_key   = '0;
        update_req   = 1'b0;
        update       = '0;
        model_rr     = 1'b0;
        test_name    = "reset";
        foreach (model0[i]) begin
            model0[i] = '0;
            model1[i] = '0;
        end

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("update_ack", 32'd0, 32'(update_ack));
        check_value("result_valid", 32'd0, 32'(result_valid));
        check_value("init_done", 32'd0, 32'(init_done));
        wait_for_init();

        test_name = "empty_lookup";
        repeat (8) begin
            rnd = $random(seed);
            issue_lookup(rnd);
        end
        stop_lookups();
        drain_results();

        test_name = "set_then_lookup";
        repeat (16) begin
            k   = $random(seed);
            rnd = $random(seed);
            run_update(1'b1, k, rnd[15:0]);
            known_keys.push_back(k);
            issue_lookup(k);
            stop_lookups();
        end
        foreach (known_keys[i]) begin
            issue_lookup(known_keys[i]);
        end
        stop_lookups();
        drain_results();

        test_name = "replace_delete";
        run_update(1'b1, known_keys[0], 16'h1234);
        issue_lookup(known_keys[0]);
        stop_lookups();
        run_update(1'b0, known_keys[1], '0);
        issue_lookup(known_keys[1]);
        stop_lookups();
        // Second delete finds nothing
        run_update(1'b0, known_keys[1], '0);
        drain_results();

        // Emptied table so the shared slots start free
        test_name = "collision_full";
        foreach (known_keys[i]) begin
            run_update(1'b0, known_keys[i], '0);
        end
        for (int i = 0; i < 3; i++) begin
            coll_keys[i] = {6'h2a, 20'(i + 1), 6'h15};
            rnd          = $random(seed);
            run_update(1'b1, coll_keys[i], rnd[15:0]);
        end
        for (int i = 0; i < 3; i++) begin
            issue_lookup(coll_keys[i]);
        end
        stop_lookups();
        drain_results();

        test_name = "back_to_back";
        for (int i = 0; i < 32; i++) begin
            rnd = $random(seed);
            if (rnd[0]) begin
                k = coll_keys[i % 3];
            end else begin
                k = rnd;
            end
            issue_lookup(k);
        end
        stop_lookups();
        drain_results();

        // Eight keys over two top and two bottom patterns
        test_name = "mixed_traffic";
        for (int i = 0; i < 8; i++) begin
            rnd     = $random(seed);
            pool[i] = {(i % 2 == 0) ? 6'h05 : 6'h31, rnd[19:0],
                       (i < 4) ? 6'h0c : 6'h22};
        end
        for (int i = 0; i < 300; i++) begin
            rnd = $random(seed);
            k   = pool[rnd[4:2]];
            case (rnd[1:0])
                2'd0, 2'd1: run_update(1'b1, k, rnd[31:16]);
                2'd2: run_update(1'b0, k, '0);
                default: begin
                    issue_lookup(k);
                    stop_lookups();
                end
            endcase
        end
        drain_results();

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
hw/htable_pkg.sv
hw/htable_bank.sv
hw/htable_insert_ctrl.sv
hw/htable_lookup_merge.sv
hw/htable_multi_core.sv
tests/htable_properties.sv
tests/htable_tb.sv
